/* include/uce_settings.svh */
`ifndef UCE_SETTINGS_SVH
`define UCE_SETTINGS_SVH

// physical address and cache geometry
`define UCE_PADDR_WIDTH 32
`define UCE_SETS 16
`define UCE_ASSOC 4
`define UCE_BLOCK_WIDTH 128
`define UCE_DWORD_WIDTH 64

// id of this cache engine on the memory side
`define UCE_LCE_ID_WIDTH 2

// limit on memory commands in flight
`define UCE_MAX_CREDITS 4
`define UCE_CREDIT_WIDTH ($clog2(`UCE_MAX_CREDITS + 1))

// derived address fields
`define UCE_BLOCK_OFFSET_WIDTH ($clog2(`UCE_BLOCK_WIDTH / 8))
`define UCE_INDEX_WIDTH ($clog2(`UCE_SETS))
`define UCE_WAY_WIDTH ($clog2(`UCE_ASSOC))
`define UCE_TAG_WIDTH (`UCE_PADDR_WIDTH - `UCE_INDEX_WIDTH - `UCE_BLOCK_OFFSET_WIDTH)

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uce_tb -f uce_top.f \
  --Mdir obj_dir -o uce_sim

./obj_dir/uce_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  exit 0
else
  exit 1
fi

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter real period_ns = 20.0
)
(
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_ns / 2.0) clk_o = ~clk_o;
  end

endmodule

/* testbench/uce_tb.sv */
`timescale 1ns/1ps
`include "uce_settings.svh"

module uce_tb import uce_pkg::*;
();

  localparam int p_clear = 0;
  localparam int p_ucst = 1;
  localparam int p_ucld = 2;
  localparam int p_clean = 3;
  localparam int p_dirty = 4;
  localparam int p_cred = 5;
  localparam int num_trans = 10;
  localparam int cycle_limit = 40 * num_trans + 2 * `UCE_SETS;
  localparam logic [`UCE_TAG_WIDTH-1:0] stub_tag = 24'h3a5c71;
  localparam logic [`UCE_BLOCK_WIDTH-1:0] stub_data = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

  logic clk_i, reset_i;
  cache_req_s cache_req_i;
  logic cache_req_v_i, cache_req_yumi_o, cache_req_busy_o;
  cache_req_metadata_s cache_req_metadata_i;
  logic cache_req_metadata_v_i, cache_req_complete_o;
  logic cache_req_credits_full_o, cache_req_credits_empty_o;
  tag_mem_pkt_s tag_mem_pkt_o;
  logic tag_mem_pkt_v_o, tag_mem_pkt_yumi_i;
  data_mem_pkt_s data_mem_pkt_o;
  logic data_mem_pkt_v_o, data_mem_pkt_yumi_i;
  stat_mem_pkt_s stat_mem_pkt_o;
  logic stat_mem_pkt_v_o, stat_mem_pkt_yumi_i;
  mem_msg_s mem_cmd_o, mem_resp_i;
  logic mem_cmd_v_o, mem_cmd_ready_i, mem_resp_v_i, mem_resp_yumi_o;

  logic [31:0] lfsr;
  logic tag_bp, data_bp, stat_bp, resp_hold, resp_taken;
  int delay, phase, errors, tests, cycles, clr_idx, complete_count, wb_count;
  mem_msg_s cmd_q[$];
  logic [`UCE_PADDR_WIDTH-1:0] exp_addr;
  logic [`UCE_WAY_WIDTH-1:0] exp_way;
  logic [`UCE_BLOCK_WIDTH-1:0] exp_block;

  wire [`UCE_INDEX_WIDTH-1:0] exp_index = exp_addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  wire [`UCE_TAG_WIDTH-1:0] exp_tag = exp_addr[`UCE_PADDR_WIDTH-1 -: `UCE_TAG_WIDTH];
  wire is_miss_phase = (phase == p_clean) || (phase == p_dirty);

  tb_clock_gen #(.period_ns(20.0)) i_clock_gen (.clk_o(clk_i));

  uce_top i_uce_top (.*, .lce_id_i(2'd1), .tag_mem_i({e_coh_m, stub_tag}), .data_mem_i(stub_data));

  // cache stub accepts packets whenever its random bit allows
  assign tag_mem_pkt_yumi_i = tag_mem_pkt_v_o & tag_bp;
  assign data_mem_pkt_yumi_i = data_mem_pkt_v_o & data_bp;
  assign stat_mem_pkt_yumi_i = stat_mem_pkt_v_o & stat_bp;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [`UCE_BLOCK_WIDTH-1:0] block_pattern(input logic [31:0] a);
    return {a ^ 32'h5a5a_0f0f, ~a, a * 32'd3, a + 32'h1234};
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  // stub back-pressure and memory model, all driven on the falling edge
  always @(negedge clk_i)
  begin
    take_bit(tag_bp);
    take_bit(data_bp);
    take_bit(stat_bp);
    if (resp_taken)
      mem_resp_v_i = 1'b0;
    if (!mem_resp_v_i)
    begin
      if (delay > 0)
        delay--;
      else if (cmd_q.size() > 0 && !resp_hold)
      begin
        mem_resp_i = cmd_q.pop_front();
        if (mem_resp_i.msg_type inside {e_mem_rd, e_mem_uc_rd})
          mem_resp_i.data = block_pattern(mem_resp_i.addr);
        mem_resp_v_i = 1'b1;
        delay = {30'b0, lfsr[1:0]};
        lfsr = lfsr_step(lfsr_step(lfsr));
      end
    end
  end

  always @(posedge clk_i)
  begin
    resp_taken <= mem_resp_v_i && mem_resp_yumi_o;
    if (!reset_i)
    begin
      if (phase == p_clear && tag_mem_pkt_v_o && tag_mem_pkt_yumi_i && stat_mem_pkt_yumi_i)
        clr_idx <= clr_idx + 1;
      if (cache_req_complete_o)
        complete_count <= complete_count + 1;
      if (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_wr)
        wb_count <= wb_count + 1;
      if (mem_cmd_v_o)
        cmd_q.push_back(mem_cmd_o);
    end
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_clear && tag_mem_pkt_v_o) |-> (tag_mem_pkt_o.opcode == e_tag_mem_set_clear
    && tag_mem_pkt_o.index == clr_idx[3:0] && stat_mem_pkt_v_o && cache_req_busy_o
    && stat_mem_pkt_o.opcode == e_stat_mem_set_clear && stat_mem_pkt_o.index == clr_idx[3:0]))
    else report_mismatch("clear packet out of order or busy low");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_clear && cache_req_complete_o) |-> (clr_idx == `UCE_SETS - 1))
    else report_mismatch("clear complete before the last index");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_req_yumi_o && cache_req_i.msg_type == e_uc_store) |-> (mem_cmd_v_o
    && mem_cmd_o.msg_type == e_mem_uc_wr && mem_cmd_o.addr == cache_req_i.addr
    && mem_cmd_o.size == cache_req_i.size && mem_cmd_o.data[63:0] == cache_req_i.data))
    else report_mismatch("uncached store command wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_ucst) |-> !cache_req_complete_o)
    else report_mismatch("complete after an uncached store");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_ucld && mem_cmd_v_o) |-> (mem_cmd_o.msg_type == e_mem_uc_rd
    && mem_cmd_o.addr == exp_addr))
    else report_mismatch("uncached read command wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_ucld && data_mem_pkt_v_o) |-> (data_mem_pkt_o.opcode == e_data_mem_uncached
    && data_mem_pkt_o.data == {2{exp_block[63:0]}}))
    else report_mismatch("uncached data packet wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_ucld && cache_req_complete_o) |-> data_mem_pkt_yumi_i)
    else report_mismatch("uncached complete without data accept");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (is_miss_phase && mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_rd) |-> (mem_cmd_o.addr
    == exp_addr && mem_cmd_o.way == exp_way && mem_cmd_o.size == mem_size_block))
    else report_mismatch("miss read command wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (is_miss_phase && tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == e_tag_mem_set_tag)
    |-> (tag_mem_pkt_o.state == e_coh_m && tag_mem_pkt_o.tag == exp_tag
    && tag_mem_pkt_o.index == exp_index && tag_mem_pkt_o.way == exp_way
    && data_mem_pkt_v_o && data_mem_pkt_o.data == exp_block))
    else report_mismatch("fill packets wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_clean) |-> !(mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_wr))
    else report_mismatch("writeback after a clean miss");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_dirty && stat_mem_pkt_v_o) |-> (stat_mem_pkt_o.opcode == e_stat_mem_clear_dirty
    && stat_mem_pkt_o.way == exp_way && stat_mem_pkt_o.index == exp_index
    && data_mem_pkt_v_o && data_mem_pkt_o.opcode == e_data_mem_read
    && data_mem_pkt_o.way == exp_way && tag_mem_pkt_o.way == exp_way
    && tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == e_tag_mem_read))
    else report_mismatch("evict packets wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_dirty && mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_wr) |-> (mem_cmd_o.addr
    == {stub_tag, exp_index, 4'h0} && mem_cmd_o.data == stub_data))
    else report_mismatch("writeback command wrong");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (phase == p_cred && cache_req_credits_full_o) |-> (!cache_req_yumi_o && cache_req_busy_o))
    else report_mismatch("request accepted with credits full");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_resp_v_i && mem_resp_i.msg_type inside {e_mem_wr, e_mem_uc_wr}) |-> mem_resp_yumi_o)
    else report_mismatch("write response not acknowledged at once");

  task automatic send_req(input cache_req_msg_e kind, input logic [31:0] addr,
                          input logic [2:0] size, input logic [63:0] data,
                          input logic [1:0] way, input logic dirty);
    @(negedge clk_i);
    cache_req_i.msg_type = kind;
    cache_req_i.addr = addr;
    cache_req_i.size = size;
    cache_req_i.data = data;
    cache_req_metadata_i.way = way;
    cache_req_metadata_i.dirty = dirty;
    cache_req_v_i = 1'b1;
    cache_req_metadata_v_i = 1'b1;
    @(posedge clk_i);
    while (!cache_req_yumi_o)
      @(posedge clk_i);
    @(negedge clk_i);
    cache_req_v_i = 1'b0;
    cache_req_metadata_v_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    while (!(cache_req_credits_empty_o && cmd_q.size() == 0 && !mem_resp_v_i))
      @(posedge clk_i);
  endtask

  task automatic wait_complete(input int start);
    while (complete_count <= start)
      @(posedge clk_i);
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests++;
    $display("%s: %s", name, (errors == start_errors) ? "ok" : "failed");
  endtask

  task automatic run_miss(input int ph, input string name, input logic dirty);
    int e0;
    e0 = errors;
    @(negedge clk_i);
    phase = ph;
    exp_addr = dirty ? 32'h7654_3a40 : 32'h1234_5670;
    exp_way = dirty ? 2'd1 : 2'd2;
    exp_block = block_pattern(exp_addr);
    send_req(dirty ? e_miss_store : e_miss_load, exp_addr | 32'h8, 3'd3, 64'h0, exp_way, dirty);
    wait_complete(complete_count);
    if (dirty)
      while (wb_count < 1)
        @(posedge clk_i);
    wait_idle();
    repeat (5) @(posedge clk_i);
    assert (wb_count == (dirty ? 1 : 0)) else report_mismatch("wrong writeback count");
    end_test(name, e0);
  endtask

  initial
  begin
    int e0;
    lfsr = 32'hde5d7a7e;
    errors = 0;
    tests = 0;
    cycles = 0;
    clr_idx = 0;
    complete_count = 0;
    wb_count = 0;
    delay = 0;
    phase = p_clear;
    tag_bp = 1'b0;
    data_bp = 1'b0;
    stat_bp = 1'b0;
    resp_hold = 1'b0;
    resp_taken = 1'b0;
    reset_i = 1'b1;
    cache_req_i = '0;
    cache_req_v_i = 1'b0;
    cache_req_metadata_i = '0;
    cache_req_metadata_v_i = 1'b0;
    mem_cmd_ready_i = 1'b1;
    mem_resp_i = '0;
    mem_resp_v_i = 1'b0;
    exp_addr = '0;
    exp_way = '0;
    exp_block = '0;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    e0 = errors;
    wait_complete(0);
    repeat (3) @(posedge clk_i);
    assert (clr_idx == `UCE_SETS && complete_count == 1)
      else report_mismatch("clear sweep count wrong");
    end_test("clear sweep", e0);

    e0 = errors;
    phase = p_ucst;
    send_req(e_uc_store, 32'h0000_2468, 3'd3, 64'hdead_0bad_1357_9bdf, 2'd0, 1'b0);
    wait_idle();
    end_test("uncached store", e0);

    e0 = errors;
    @(negedge clk_i);
    phase = p_ucld;
    exp_addr = 32'h0000_13a8;
    exp_block = block_pattern(exp_addr);
    send_req(e_uc_load, exp_addr, 3'd3, 64'h0, 2'd0, 1'b0);
    wait_complete(complete_count);
    wait_idle();
    end_test("uncached load", e0);

    run_miss(p_clean, "clean miss", 1'b0);
    run_miss(p_dirty, "dirty miss", 1'b1);

    e0 = errors;
    @(negedge clk_i);
    phase = p_cred;
    resp_hold = 1'b1;
    for (int i = 0; i < `UCE_MAX_CREDITS; i++)
      send_req(e_uc_store, 32'h0000_4000 + 32'(i * 8), 3'd3, 64'(i), 2'd0, 1'b0);
    assert (cache_req_credits_full_o && cache_req_busy_o)
      else report_mismatch("credits not full after four stores");
    cache_req_i.addr = 32'h0000_5000;
    cache_req_v_i = 1'b1;
    repeat (8) @(negedge clk_i);
    cache_req_v_i = 1'b0;
    resp_hold = 1'b0;
    // every held response has been handed out and taken
    @(posedge clk_i);
    while (cmd_q.size() > 0 || mem_resp_v_i)
      @(posedge clk_i);
    assert (cache_req_credits_empty_o) else report_mismatch("credits not empty after acks");
    end_test("credits", e0);

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* uce_top.f */
+incdir+include
verilog/uce_pkg.sv
verilog/uce_req_if.sv
verilog/uce_req_capture.sv
verilog/uce_readout_reg.sv
verilog/uce_ctrl.sv
verilog/uce_top.sv
testbench/tb_clock_gen.sv
testbench/uce_tb.sv

/* verilog/uce_ctrl.sv */
`timescale 1ns/1ps
`include "uce_settings.svh"

module uce_ctrl import uce_pkg::*;
(
  input logic clk_i
  , input logic reset_i
  , input logic [`UCE_LCE_ID_WIDTH-1:0] lce_id_i

  , uce_req_if.ctrl req_bus
  , input cache_req_s cache_req_i
  , input logic cache_req_v_i
  , output logic cache_req_busy_o
  , output logic credits_full_o
  , output logic credits_empty_o

  , output tag_mem_pkt_s tag_mem_pkt_o
  , output logic tag_mem_pkt_v_o
  , input logic tag_mem_pkt_yumi_i
  , output data_mem_pkt_s data_mem_pkt_o
  , output logic data_mem_pkt_v_o
  , input logic data_mem_pkt_yumi_i
  , output stat_mem_pkt_s stat_mem_pkt_o
  , output logic stat_mem_pkt_v_o
  , input logic stat_mem_pkt_yumi_i

  , output logic tag_capture_o
  , output logic data_capture_o
  , input tag_info_s dirty_tag_i
  , input logic dirty_tag_v_i
  , input logic [`UCE_BLOCK_WIDTH-1:0] dirty_data_i
  , input logic dirty_data_v_i

  , output mem_msg_s mem_cmd_o
  , output logic mem_cmd_v_o
  , input logic mem_cmd_ready_i
  , input mem_msg_s mem_resp_i
  , input logic mem_resp_v_i
  , output logic mem_resp_yumi_o
);

  localparam int index_width_lp = `UCE_INDEX_WIDTH;
  localparam int credit_width_lp = `UCE_CREDIT_WIDTH;
  localparam logic [credit_width_lp-1:0] credit_max_lp =
    credit_width_lp'(`UCE_MAX_CREDITS);

  typedef enum logic [2:0]
  {
    e_reset
    , e_clear
    , e_ready
    , e_send_miss
    , e_evict
    , e_fill
    , e_writeback
    , e_uc_wait
  } state_e;

  state_e state_r, state_n;
  logic [index_width_lp-1:0] index_r;
  logic index_up;
  logic [credit_width_lp-1:0] credit_r;
  logic resp_yumi_lo;

  logic [index_width_lp-1:0] req_index;
  logic [index_width_lp-1:0] resp_index;
  logic [`UCE_TAG_WIDTH-1:0] resp_tag;
  logic [`UCE_PADDR_WIDTH-1:0] block_addr;

  wire index_done = &index_r;
  wire is_miss = req_bus.req.msg_type inside {e_miss_load, e_miss_store};
  wire is_uc_store = (cache_req_i.msg_type == e_uc_store);
  wire is_clear_req = (cache_req_i.msg_type == e_cache_clear);
  wire store_resp_v = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_wr, e_mem_uc_wr});
  wire load_resp_v = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_rd, e_mem_uc_rd});
  wire fill_yumi = tag_mem_pkt_yumi_i & data_mem_pkt_yumi_i;
  wire evict_yumi = fill_yumi & stat_mem_pkt_yumi_i;

  assign req_index = req_bus.req.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  assign resp_index = mem_resp_i.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  assign resp_tag = mem_resp_i.addr[`UCE_PADDR_WIDTH-1 -: `UCE_TAG_WIDTH];
  assign block_addr = {req_bus.req.addr[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH],
                       {`UCE_BLOCK_OFFSET_WIDTH{1'b0}}};

  // all three evict packets are accepted together, so both readouts start at once
  assign tag_capture_o = (state_r == e_evict) & evict_yumi;
  assign data_capture_o = (state_r == e_evict) & evict_yumi;

  assign credits_full_o = (credit_r == credit_max_lp);
  assign credits_empty_o = (credit_r == '0);
  assign cache_req_busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_o;

  // write acks carry nothing for the cache
  assign mem_resp_yumi_o = resp_yumi_lo | store_resp_v;

  always_comb
  begin
    state_n = state_r;
    index_up = 1'b0;
    resp_yumi_lo = 1'b0;
    req_bus.accept = 1'b0;
    req_bus.done = 1'b0;

    tag_mem_pkt_o = '0;
    tag_mem_pkt_v_o = 1'b0;
    data_mem_pkt_o = '0;
    data_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_o = '0;
    stat_mem_pkt_v_o = 1'b0;

    mem_cmd_o = '0;
    mem_cmd_o.lce_id = lce_id_i;
    mem_cmd_v_o = 1'b0;

    unique case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_mem_pkt_o.opcode = e_tag_mem_set_clear;
        tag_mem_pkt_o.index = index_r;
        tag_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_mem_set_clear;
        stat_mem_pkt_o.index = index_r;
        stat_mem_pkt_v_o = 1'b1;

        index_up = tag_mem_pkt_yumi_i & stat_mem_pkt_yumi_i;
        req_bus.done = index_done & index_up;
        state_n = req_bus.done ? e_ready : e_clear;
      end
      e_ready:
      begin
        req_bus.accept = cache_req_v_i & mem_cmd_ready_i & ~credits_full_o;
        if (is_uc_store)
        begin
          // the store goes out with the yumi
          mem_cmd_o.msg_type = e_mem_uc_wr;
          mem_cmd_o.addr = cache_req_i.addr;
          mem_cmd_o.size = cache_req_i.size;
          mem_cmd_o.data[`UCE_DWORD_WIDTH-1:0] = cache_req_i.data;
          mem_cmd_v_o = req_bus.accept;
        end
        else if (req_bus.accept)
          state_n = is_clear_req ? e_clear : e_send_miss;
      end
      e_send_miss:
      begin
        if (is_miss)
        begin
          mem_cmd_o.msg_type = e_mem_rd;
          mem_cmd_o.addr = block_addr;
          mem_cmd_o.size = mem_size_block;
          mem_cmd_o.way = req_bus.meta.way;
          mem_cmd_v_o = mem_cmd_ready_i & req_bus.req_v & req_bus.meta_v & ~credits_full_o;
          if (mem_cmd_v_o)
            state_n = req_bus.meta.dirty ? e_evict : e_fill;
        end
        else
        begin
          mem_cmd_o.msg_type = e_mem_uc_rd;
          mem_cmd_o.addr = req_bus.req.addr;
          mem_cmd_o.size = req_bus.req.size;
          mem_cmd_v_o = mem_cmd_ready_i & req_bus.req_v & ~credits_full_o;
          if (mem_cmd_v_o)
            state_n = e_uc_wait;
        end
      end
      e_evict:
      begin
        // read the victim out and drop its dirty bit in one go
        data_mem_pkt_o.opcode = e_data_mem_read;
        data_mem_pkt_o.index = req_index;
        data_mem_pkt_o.way = req_bus.meta.way;
        data_mem_pkt_v_o = 1'b1;
        tag_mem_pkt_o.opcode = e_tag_mem_read;
        tag_mem_pkt_o.index = req_index;
        tag_mem_pkt_o.way = req_bus.meta.way;
        tag_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_mem_clear_dirty;
        stat_mem_pkt_o.index = req_index;
        stat_mem_pkt_o.way = req_bus.meta.way;
        stat_mem_pkt_v_o = 1'b1;
        state_n = evict_yumi ? e_fill : e_evict;
      end
      e_fill:
      begin
        // filled lines go straight to modified
        tag_mem_pkt_o.opcode = e_tag_mem_set_tag;
        tag_mem_pkt_o.index = resp_index;
        tag_mem_pkt_o.way = mem_resp_i.way;
        tag_mem_pkt_o.state = e_coh_m;
        tag_mem_pkt_o.tag = resp_tag;
        tag_mem_pkt_v_o = load_resp_v;
        data_mem_pkt_o.opcode = e_data_mem_write;
        data_mem_pkt_o.index = resp_index;
        data_mem_pkt_o.way = mem_resp_i.way;
        data_mem_pkt_o.data = mem_resp_i.data;
        data_mem_pkt_v_o = load_resp_v;

        resp_yumi_lo = fill_yumi;
        req_bus.done = fill_yumi;
        if (fill_yumi)
          state_n = req_bus.meta.dirty ? e_writeback : e_ready;
      end
      e_writeback:
      begin
        mem_cmd_o.msg_type = e_mem_wr;
        mem_cmd_o.addr = {dirty_tag_i.tag, req_index, {`UCE_BLOCK_OFFSET_WIDTH{1'b0}}};
        mem_cmd_o.size = mem_size_block;
        mem_cmd_o.way = req_bus.meta.way;
        mem_cmd_o.data = dirty_data_i;
        mem_cmd_v_o = mem_cmd_ready_i & dirty_tag_v_i & dirty_data_v_i & ~credits_full_o;
        state_n = mem_cmd_v_o ? e_ready : e_writeback;
      end
      e_uc_wait:
      begin
        data_mem_pkt_o.opcode = e_data_mem_uncached;
        data_mem_pkt_o.data =
          {(`UCE_BLOCK_WIDTH / `UCE_DWORD_WIDTH){mem_resp_i.data[`UCE_DWORD_WIDTH-1:0]}};
        data_mem_pkt_v_o = load_resp_v;
        resp_yumi_lo = data_mem_pkt_yumi_i;
        req_bus.done = data_mem_pkt_yumi_i;
        state_n = data_mem_pkt_yumi_i ? e_ready : e_uc_wait;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_reset;
    else
      state_r <= state_n;
  end

  // wraps to zero after the last set, ready for a later clear request
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      index_r <= '0;
    else if (index_up)
      index_r <= index_r + index_width_lp'(1);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credit_r <= '0;
    else if (mem_cmd_v_o & ~mem_resp_yumi_o)
      credit_r <= credit_r + credit_width_lp'(1);
    else if (mem_resp_yumi_o & ~mem_cmd_v_o)
      credit_r <= credit_r - credit_width_lp'(1);
  end

  assert property (@(posedge clk_i) disable iff (reset_i) mem_cmd_v_o |-> mem_cmd_ready_i);

  assert property (@(posedge clk_i) disable iff (reset_i) credit_r <= credit_max_lp);

  assert property (@(posedge clk_i) disable iff (reset_i) req_bus.accept |-> !cache_req_busy_o);

endmodule

/* verilog/uce_pkg.sv */
`include "uce_settings.svh"

package uce_pkg;

  typedef enum logic [2:0]
  {
    e_miss_load
    , e_miss_store
    , e_uc_load
    , e_uc_store
    , e_cache_clear
  } cache_req_msg_e;

  typedef struct packed
  {
    cache_req_msg_e msg_type;
    logic [`UCE_PADDR_WIDTH-1:0] addr;
    logic [2:0] size;
    logic [`UCE_DWORD_WIDTH-1:0] data;
  } cache_req_s;

  typedef struct packed
  {
    logic [`UCE_WAY_WIDTH-1:0] way;
    logic dirty;
  } cache_req_metadata_s;

  typedef enum logic
  {
    e_coh_i
    , e_coh_m
  } coh_state_e;

  typedef enum logic [1:0]
  {
    e_tag_mem_set_clear
    , e_tag_mem_read
    , e_tag_mem_set_tag
  } tag_mem_op_e;

  typedef enum logic [1:0]
  {
    e_data_mem_read
    , e_data_mem_write
    , e_data_mem_uncached
  } data_mem_op_e;

  typedef enum logic
  {
    e_stat_mem_set_clear
    , e_stat_mem_clear_dirty
  } stat_mem_op_e;

  typedef struct packed
  {
    tag_mem_op_e opcode;
    logic [`UCE_INDEX_WIDTH-1:0] index;
    logic [`UCE_WAY_WIDTH-1:0] way;
    coh_state_e state;
    logic [`UCE_TAG_WIDTH-1:0] tag;
  } tag_mem_pkt_s;

  typedef struct packed
  {
    data_mem_op_e opcode;
    logic [`UCE_INDEX_WIDTH-1:0] index;
    logic [`UCE_WAY_WIDTH-1:0] way;
    logic [`UCE_BLOCK_WIDTH-1:0] data;
  } data_mem_pkt_s;

  typedef struct packed
  {
    stat_mem_op_e opcode;
    logic [`UCE_INDEX_WIDTH-1:0] index;
    logic [`UCE_WAY_WIDTH-1:0] way;
  } stat_mem_pkt_s;

  typedef struct packed
  {
    coh_state_e state;
    logic [`UCE_TAG_WIDTH-1:0] tag;
  } tag_info_s;

  typedef enum logic [1:0]
  {
    e_mem_rd
    , e_mem_wr
    , e_mem_uc_rd
    , e_mem_uc_wr
  } mem_msg_e;

  typedef struct packed
  {
    mem_msg_e msg_type;
    logic [`UCE_PADDR_WIDTH-1:0] addr;
    logic [2:0] size;
    logic [`UCE_WAY_WIDTH-1:0] way;
    logic [`UCE_LCE_ID_WIDTH-1:0] lce_id;
    logic [`UCE_BLOCK_WIDTH-1:0] data;
  } mem_msg_s;

  // size codes are log2 of the byte count, a block is 16 bytes
  localparam logic [2:0] mem_size_block = 3'd4;

endpackage

/* verilog/uce_readout_reg.sv */
`timescale 1ns/1ps

module uce_readout_reg
#(
  parameter type payload_t = logic
)
(
  input logic clk_i
  , input logic reset_i

  , input logic capture_i
  , input payload_t data_i
  , output payload_t data_o
  , output logic valid_o
);

  // synchronous read, so the output shows up one cycle after the accept
  logic pending_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pending_r <= 1'b0;
    else
      pending_r <= capture_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (pending_r)
      data_o <= data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_o <= 1'b0;
    else if (capture_i)
      valid_o <= 1'b0;
    else if (pending_r)
      valid_o <= 1'b1;
  end

  // a second read in the next cycle would drop the first readout
  assert property (@(posedge clk_i) disable iff (reset_i) pending_r |-> !capture_i);

endmodule

/* verilog/uce_req_capture.sv */
`timescale 1ns/1ps

module uce_req_capture import uce_pkg::*;
(
  input logic clk_i
  , input logic reset_i

  , input cache_req_s cache_req_i
  , input cache_req_metadata_s cache_req_metadata_i
  , input logic cache_req_metadata_v_i

  , uce_req_if.capture req_bus
);

  always_ff @(posedge clk_i)
  begin
    if (req_bus.accept)
      req_bus.req <= cache_req_i;
  end

  // held from accept until the request completes
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req_bus.req_v <= 1'b0;
    else if (req_bus.accept)
      req_bus.req_v <= 1'b1;
    else if (req_bus.done)
      req_bus.req_v <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_metadata_v_i)
      req_bus.meta <= cache_req_metadata_i;
  end

  // a new request invalidates old metadata, new metadata wins a tie
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req_bus.meta_v <= 1'b0;
    else if (cache_req_metadata_v_i)
      req_bus.meta_v <= 1'b1;
    else if (req_bus.accept)
      req_bus.meta_v <= 1'b0;
  end

endmodule

/* verilog/uce_req_if.sv */
`timescale 1ns/1ps

interface uce_req_if import uce_pkg::*; ();

  cache_req_s req;
  logic req_v;
  cache_req_metadata_s meta;
  logic meta_v;

  // accept is the cache yumi, done is the completion pulse
  logic accept;
  logic done;

  modport capture
  (
    input accept
    , input done
    , output req
    , output req_v
    , output meta
    , output meta_v
  );

  modport ctrl
  (
    output accept
    , output done
    , input req
    , input req_v
    , input meta
    , input meta_v
  );

endinterface

/* verilog/uce_top.sv */
`timescale 1ns/1ps
`include "uce_settings.svh"

module uce_top import uce_pkg::*;
(
  input logic clk_i
  , input logic reset_i
  , input logic [`UCE_LCE_ID_WIDTH-1:0] lce_id_i

  , input cache_req_s cache_req_i
  , input logic cache_req_v_i
  , output logic cache_req_yumi_o
  , output logic cache_req_busy_o
  , input cache_req_metadata_s cache_req_metadata_i
  , input logic cache_req_metadata_v_i
  , output logic cache_req_complete_o
  , output logic cache_req_credits_full_o
  , output logic cache_req_credits_empty_o

  , output tag_mem_pkt_s tag_mem_pkt_o
  , output logic tag_mem_pkt_v_o
  , input logic tag_mem_pkt_yumi_i
  , input tag_info_s tag_mem_i

  , output data_mem_pkt_s data_mem_pkt_o
  , output logic data_mem_pkt_v_o
  , input logic data_mem_pkt_yumi_i
  , input logic [`UCE_BLOCK_WIDTH-1:0] data_mem_i

  , output stat_mem_pkt_s stat_mem_pkt_o
  , output logic stat_mem_pkt_v_o
  , input logic stat_mem_pkt_yumi_i

  , output mem_msg_s mem_cmd_o
  , output logic mem_cmd_v_o
  , input logic mem_cmd_ready_i

  , input mem_msg_s mem_resp_i
  , input logic mem_resp_v_i
  , output logic mem_resp_yumi_o
);

  uce_req_if req_bus ();

  logic tag_capture, data_capture;
  tag_info_s dirty_tag;
  logic dirty_tag_v;
  logic [`UCE_BLOCK_WIDTH-1:0] dirty_data;
  logic dirty_data_v;

  assign cache_req_yumi_o = req_bus.accept;
  assign cache_req_complete_o = req_bus.done;

  uce_req_capture i_req_capture
  (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .cache_req_i(cache_req_i)
    , .cache_req_metadata_i(cache_req_metadata_i)
    , .cache_req_metadata_v_i(cache_req_metadata_v_i)
    , .req_bus(req_bus.capture)
  );

  // victim tag and data, read from the cache before the fill overwrites them
  uce_readout_reg #(.payload_t(tag_info_s)) i_tag_readout
  (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .capture_i(tag_capture)
    , .data_i(tag_mem_i)
    , .data_o(dirty_tag)
    , .valid_o(dirty_tag_v)
  );

  uce_readout_reg #(.payload_t(logic [`UCE_BLOCK_WIDTH-1:0])) i_data_readout
  (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .capture_i(data_capture)
    , .data_i(data_mem_i)
    , .data_o(dirty_data)
    , .valid_o(dirty_data_v)
  );

  uce_ctrl i_ctrl
  (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .lce_id_i(lce_id_i)
    , .req_bus(req_bus.ctrl)
    , .cache_req_i(cache_req_i)
    , .cache_req_v_i(cache_req_v_i)
    , .cache_req_busy_o(cache_req_busy_o)
    , .credits_full_o(cache_req_credits_full_o)
    , .credits_empty_o(cache_req_credits_empty_o)
    , .tag_mem_pkt_o(tag_mem_pkt_o)
    , .tag_mem_pkt_v_o(tag_mem_pkt_v_o)
    , .tag_mem_pkt_yumi_i(tag_mem_pkt_yumi_i)
    , .data_mem_pkt_o(data_mem_pkt_o)
    , .data_mem_pkt_v_o(data_mem_pkt_v_o)
    , .data_mem_pkt_yumi_i(data_mem_pkt_yumi_i)
    , .stat_mem_pkt_o(stat_mem_pkt_o)
    , .stat_mem_pkt_v_o(stat_mem_pkt_v_o)
    , .stat_mem_pkt_yumi_i(stat_mem_pkt_yumi_i)
    , .tag_capture_o(tag_capture)
    , .data_capture_o(data_capture)
    , .dirty_tag_i(dirty_tag)
    , .dirty_tag_v_i(dirty_tag_v)
    , .dirty_data_i(dirty_data)
    , .dirty_data_v_i(dirty_data_v)
    , .mem_cmd_o(mem_cmd_o)
    , .mem_cmd_v_o(mem_cmd_v_o)
    , .mem_cmd_ready_i(mem_cmd_ready_i)
    , .mem_resp_i(mem_resp_i)
    , .mem_resp_v_i(mem_resp_v_i)
    , .mem_resp_yumi_o(mem_resp_yumi_o)
  );

endmodule
